//--- all.f
+incdir+hw
hw/slc3Pkg.sv
hw/controlUnit.sv
hw/datapath.sv
hw/apbMaster.sv
hw/slc3Top.sv
testbench/apbMemory.sv
testbench/slc3Tb.sv

//--- Bender.yml
package:
  name: slc3

sources:
  - include_dirs:
      - hw
    files:
      - hw/slc3Pkg.sv
      - hw/controlUnit.sv
      - hw/datapath.sv
      - hw/apbMaster.sv
      - hw/slc3Top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/apbMemory.sv
      - testbench/slc3Tb.sv

//--- testbench/slc3Tb.sv
// Testbench for slc3Top; random programs, an ISA reference model and APB bus checks
`timescale 1ns/1ns
`default_nettype none

`include "slc3_settings.svh"

module slc3Tb;

	localparam int NumProgs = 3;
	localparam int NumItems = 40;

	logic        Clk;
	logic        Reset;
	logic        Run;
	logic        Continue;
	logic [1:0]  waitDraw;
	logic [15:0] pAddr;
	logic        pSel;
	logic        pEnable;
	logic        pWrite;
	logic [15:0] pWData;
	logic [15:0] pRData;
	logic        pReady;
	logic        paused;
	logic [15:0] irDisplay;

	logic [31:0] rngState;
	logic [15:0] refMem [0:4095];
	int          cursor;
	logic [15:0] readQ [$];
	logic [15:0] writeAddrQ [$];
	logic [15:0] writeDataQ [$];
	logic [15:0] pauseIr [NumProgs];
	logic [15:0] finalPc;
	int          logSeen;
	int          cycles;
	int          cycleLimit;

	// Bus state from the previous edge
	logic        prevSetup;
	logic        prevWaiting;
	logic [15:0] prevAddr;
	logic        prevWrite;
	logic [15:0] prevWData;

	slc3Top u_slc3Top
	(
		.Clk       (Clk),
		.Reset     (Reset),
		.Run       (Run),
		.Continue  (Continue),
		.PRData    (pRData),
		.PReady    (pReady),
		.PAddr     (pAddr),
		.PSel      (pSel),
		.PEnable   (pEnable),
		.PWrite    (pWrite),
		.PWData    (pWData),
		.Paused    (paused),
		.IrDisplay (irDisplay)
	);

	apbMemory u_mem
	(
		.Clk      (Clk),
		.Reset    (Reset),
		.PAddr    (pAddr),
		.PSel     (pSel),
		.PEnable  (pEnable),
		.PWrite   (pWrite),
		.PWData   (pWData),
		.WaitDraw (waitDraw),
		.PRData   (pRData),
		.PReady   (pReady)
	);

	initial
	begin
		Clk = 1'b0;
		forever
			#10 Clk = ~Clk;
	end

	function automatic logic [31:0] nextRand();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	task automatic stopOnError(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
			stopOnError($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
	endtask

	// ------------------------------------------------------------------
	// Program generator
	// ------------------------------------------------------------------
	task automatic emitWord(input logic [15:0] w);
		refMem[cursor] = w;
		cursor++;
	endtask

	// Any register but R6, which holds the data base
	function automatic logic [2:0] pickDest();
		logic [2:0] r;
		r = 3'(nextRand() % 7);
		return (r == 3'd6) ? 3'd7 : r;
	endfunction

	task automatic emitAlu();
		logic [31:0] r;
		r = nextRand();
		case (r[1:0])
			2'd0: emitWord({`SLC3_OP_ADD, pickDest(), r[10:8], 1'b1, r[15:11]});
			2'd1: emitWord({`SLC3_OP_ADD, pickDest(), r[10:8], 3'b000, r[14:12]});
			2'd2: emitWord({`SLC3_OP_AND, pickDest(), r[10:8], r[16], r[15:11]});
			default: emitWord({`SLC3_OP_NOT, pickDest(), r[10:8], 6'h3F});
		endcase
	endtask

	task automatic buildProgram();
		logic [31:0] r;
		int          off;
		for (int i = 0; i < 8; i++)
		begin
			if (i != 6)
			begin
				r = nextRand();
				emitWord({`SLC3_OP_AND, 3'(i), 3'(i), 1'b1, 5'd0});
				emitWord({`SLC3_OP_ADD, 3'(i), 3'(i), 1'b1, r[4:0]});
			end
		end
		// R6 = 0x0800 by doubling
		emitWord({`SLC3_OP_AND, 3'd6, 3'd6, 1'b1, 5'd0});
		emitWord({`SLC3_OP_ADD, 3'd6, 3'd6, 1'b1, 5'd1});
		repeat (11)
			emitWord({`SLC3_OP_ADD, 3'd6, 3'd6, 3'b000, 3'd6});
		for (int i = 0; i < NumItems; i++)
		begin
			r = nextRand();
			off = int'(r[4:3]);
			case (r[2:0])
				3'd3:
				begin
					emitWord({`SLC3_OP_BR, r[7:5], 9'(off)});
					repeat (off)
						emitAlu();
				end
				3'd4:
				begin
					emitWord({`SLC3_OP_JSR, 1'b1, 11'(off)});
					repeat (off)
						emitAlu();
				end
				// JSR +0 captures PC in R7, then jump two to four words ahead
				3'd5:
				begin
					off = 2 + (off % 3);
					emitWord({`SLC3_OP_JSR, 1'b1, 11'd0});
					emitWord({`SLC3_OP_ADD, 3'd7, 3'd7, 1'b1, 5'(off)});
					emitWord({`SLC3_OP_JMP, 3'd0, 3'd7, 6'd0});
					repeat (off - 2)
						emitAlu();
				end
				3'd6: emitWord({`SLC3_OP_LDR, pickDest(), 3'd6, 2'b00, r[8:5]});
				3'd7: emitWord({`SLC3_OP_STR, r[10:8], 3'd6, 2'b00, r[8:5]});
				default: emitAlu();
			endcase
		end
		for (int i = 0; i < 8; i++)
			emitWord({`SLC3_OP_STR, 3'(i), 3'd6, 6'(16 + i)});
		r = nextRand();
		emitWord({`SLC3_OP_PAUSE, r[27:16]});
	endtask

	// ------------------------------------------------------------------
	// Instruction-level reference model
	// ------------------------------------------------------------------
	task automatic runModel();
		logic [15:0] pc;
		logic [15:0] ir;
		logic [15:0] ea;
		logic [15:0] res;
		logic [15:0] opB;
		logic [15:0] regs [8];
		logic        n;
		logic        z;
		logic        p;
		logic        setCc;
		int          pauses;
		int          steps;
		pc = '0;
		n = 1'b0;
		z = 1'b0;
		p = 1'b0;
		pauses = 0;
		steps = 0;
		res = '0;
		for (int i = 0; i < 8; i++)
			regs[i] = '0;
		while (pauses < NumProgs)
		begin
			steps++;
			if (steps > 20000)
				stopOnError("Reference model never reached the final PAUSE");
			readQ.push_back(pc);
			ir = refMem[pc[11:0]];
			pc = pc + 16'd1;
			setCc = 1'b0;
			opB = ir[5] ? {{11{ir[4]}}, ir[4:0]} : regs[ir[2:0]];
			ea = regs[ir[8:6]] + {{10{ir[5]}}, ir[5:0]};
			case (ir[15:12])
				`SLC3_OP_ADD:
				begin
					res = regs[ir[8:6]] + opB;
					setCc = 1'b1;
				end
				`SLC3_OP_AND:
				begin
					res = regs[ir[8:6]] & opB;
					setCc = 1'b1;
				end
				`SLC3_OP_NOT:
				begin
					res = ~regs[ir[8:6]];
					setCc = 1'b1;
				end
				`SLC3_OP_BR:
					if ((ir[11] & n) | (ir[10] & z) | (ir[9] & p))
						pc = pc + {{7{ir[8]}}, ir[8:0]};
				`SLC3_OP_JMP:
					pc = regs[ir[8:6]];
				`SLC3_OP_JSR:
				begin
					regs[7] = pc;
					pc = pc + {{5{ir[10]}}, ir[10:0]};
				end
				`SLC3_OP_LDR:
				begin
					readQ.push_back(ea);
					res = refMem[ea[11:0]];
					setCc = 1'b1;
				end
				`SLC3_OP_STR:
				begin
					refMem[ea[11:0]] = regs[ir[11:9]];
					writeAddrQ.push_back(ea);
					writeDataQ.push_back(regs[ir[11:9]]);
				end
				`SLC3_OP_PAUSE:
				begin
					pauseIr[pauses] = ir;
					pauses++;
				end
				default:
				begin
				end
			endcase
			if (setCc)
			begin
				regs[ir[11:9]] = res;
				n = res[15];
				z = (res == 16'd0);
				p = !res[15] && (res != 16'd0);
			end
		end
		finalPc = pc;
	endtask

	// ------------------------------------------------------------------
	// Bus monitor, wait-state draws and timeout
	// ------------------------------------------------------------------
	always @(posedge Clk)
	begin
		waitDraw <= 2'(nextRand() % 4);
	end

	always @(posedge Clk)
	begin
		cycles <= cycles + 1;
		if (cycleLimit != 0 && cycles > cycleLimit)
			stopOnError("Timeout, the processor did not reach the last PAUSE in time");
	end

	always @(posedge Clk)
	begin
		if (!Reset)
		begin
			if (!Run && pSel)
				stopOnError("APB transfer started while the processor was halted");
			if (prevSetup)
				checkValue("access after setup", 2'b11, {pSel, pEnable});
			if (prevWaiting)
			begin
				checkValue("PAddr held in wait", prevAddr, pAddr);
				checkValue("PWrite held in wait", prevWrite, pWrite);
				checkValue("PWData held in wait", prevWData, pWData);
			end
			if (pSel && pEnable && pReady && !pWrite)
			begin
				if (readQ.size() == 0)
					stopOnError("APB read that the model does not expect");
				checkValue("read address", readQ.pop_front(), pAddr);
			end
			// Each write as the memory model recorded it
			if (u_mem.logAddr.size() > logSeen)
			begin
				if (writeAddrQ.size() == 0)
					stopOnError("APB write that the model does not expect");
				checkValue("write address", writeAddrQ.pop_front(),
					u_mem.logAddr[logSeen]);
				checkValue("write data", writeDataQ.pop_front(),
					u_mem.logData[logSeen]);
				logSeen++;
			end
		end
		prevSetup   <= pSel && !pEnable;
		prevWaiting <= pSel && pEnable && !pReady;
		prevAddr    <= pAddr;
		prevWrite   <= pWrite;
		prevWData   <= pWData;
	end

	// ------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------
	initial
	begin
		Reset = 1'b1;
		Run = 1'b0;
		Continue = 1'b0;
		waitDraw = 2'd0;
		rngState = 32'd88;
		cycles = 0;
		cycleLimit = 0;
		logSeen = 0;
		prevSetup = 1'b0;
		prevWaiting = 1'b0;
		cursor = 0;
		// Fill depends on every address bit
		for (int a = 0; a < 4096; a++)
			refMem[a] = 16'(a * 40503) ^ {a[3:0], a[11:0]} ^ 16'h5A3C;
		repeat (NumProgs)
			buildProgram();
		for (int a = 0; a < 4096; a++)
			u_mem.mem[a] = refMem[a];
		runModel();
		cycleLimit = 30 * cursor + 100;

		repeat (8)
			@(posedge Clk);
		Reset <= 1'b0;
		@(posedge Clk);
		Run <= 1'b1;
		for (int k = 0; k < NumProgs; k++)
		begin
			while (!paused)
				@(posedge Clk);
			checkValue($sformatf("IR at pause %0d", k), pauseIr[k], irDisplay);
			if (k < NumProgs - 1)
			begin
				Continue <= 1'b1;
				repeat (3)
					@(posedge Clk);
				Continue <= 1'b0;
				while (paused)
					@(posedge Clk);
			end
		end
		checkValue("reads left over", 0, readQ.size());
		checkValue("writes left over", 0, writeAddrQ.size());
		checkValue("final PC", finalPc, u_slc3Top.u_datapath.pc);
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/apbMemory.sv
// APB slave memory for the testbench; random wait states per transfer and a log of every write
`timescale 1ns/1ns
`default_nettype none

`include "slc3_settings.svh"

module apbMemory
(
	input  wire                          Clk,
	input  wire                          Reset,
	input  wire [`SLC3_WORD_WIDTH-1:0]   PAddr,
	input  wire                          PSel,
	input  wire                          PEnable,
	input  wire                          PWrite,
	input  wire [`SLC3_WORD_WIDTH-1:0]   PWData,
	input  wire [1:0]                    WaitDraw,
	output logic [`SLC3_WORD_WIDTH-1:0]  PRData,
	output logic                         PReady
);

	// 4K words preloaded by the testbench through the hierarchy
	logic [`SLC3_WORD_WIDTH-1:0] mem [0:4095];
	logic [`SLC3_WORD_WIDTH-1:0] logAddr [$];
	logic [`SLC3_WORD_WIDTH-1:0] logData [$];
	logic [1:0]                  waitLeft;

	assign PRData = mem[PAddr[11:0]];
	assign PReady = (waitLeft == 2'd0);

	// Wait count is drawn in the setup phase and runs down during access
	always @(posedge Clk or posedge Reset)
	begin
		if (Reset)
			waitLeft <= 2'd0;
		else if (PSel && !PEnable)
			waitLeft <= WaitDraw;
		else if (PSel && PEnable && waitLeft != 2'd0)
			waitLeft <= waitLeft - 2'd1;
	end

	always @(posedge Clk)
	begin
		if (PSel && PEnable && PReady && PWrite)
		begin
			mem[PAddr[11:0]] <= PWData;
			logAddr.push_back(PAddr);
			logData.push_back(PWData);
		end
	end

endmodule

`default_nettype wire

//--- hw/slc3Top.sv
// SLC-3 processor top level; connects sequencer, datapath and APB port to the switches
`timescale 1ns/1ns
`default_nettype none

`include "slc3_settings.svh"

module slc3Top import slc3Pkg::*;
(
	input  wire                          Clk,
	input  wire                          Reset,
	input  wire                          Run,
	input  wire                          Continue,
	input  wire [`SLC3_WORD_WIDTH-1:0]   PRData,
	input  wire                          PReady,
	output logic [`SLC3_WORD_WIDTH-1:0]  PAddr,
	output logic                         PSel,
	output logic                         PEnable,
	output logic                         PWrite,
	output logic [`SLC3_WORD_WIDTH-1:0]  PWData,
	output logic                         Paused,
	output logic [`SLC3_WORD_WIDTH-1:0]  IrDisplay
);

	// Sequencer control word
	logic       ldMar;
	logic       ldIr;
	logic       ldBen;
	logic       ldCc;
	logic       ldReg;
	logic       ldPc;
	logic       gatePc;
	logic       gateMdr;
	logic       gateAlu;
	logic       gateMarMux;
	logic [1:0] pcMux;
	logic       drMux;
	logic       sr1Mux;
	logic       sr2Mux;
	logic       addr1Mux;
	logic [1:0] addr2Mux;
	aluOpT      aluOp;

	// Decode feedback and memory handshake
	opcodeT                      opcode;
	logic                        immFlag;
	logic                        ben;
	logic                        memRead;
	logic                        memWrite;
	logic                        memDone;
	logic                        ldMdrMem;
	logic [`SLC3_WORD_WIDTH-1:0] mar;
	logic [`SLC3_WORD_WIDTH-1:0] mdr;
	logic [`SLC3_WORD_WIDTH-1:0] rData;

	controlUnit u_controlUnit
	(
		.Clk        (Clk),
		.Reset      (Reset),
		.Run        (Run),
		.Continue   (Continue),
		.Opcode     (opcode),
		.ImmFlag    (immFlag),
		.Ben        (ben),
		.MemDone    (memDone),
		.LdMar      (ldMar),
		.LdIr       (ldIr),
		.LdBen      (ldBen),
		.LdCc       (ldCc),
		.LdReg      (ldReg),
		.LdPc       (ldPc),
		.GatePc     (gatePc),
		.GateMdr    (gateMdr),
		.GateAlu    (gateAlu),
		.GateMarMux (gateMarMux),
		.PcMux      (pcMux),
		.DrMux      (drMux),
		.Sr1Mux     (sr1Mux),
		.Sr2Mux     (sr2Mux),
		.Addr1Mux   (addr1Mux),
		.Addr2Mux   (addr2Mux),
		.AluOp      (aluOp),
		.MemRead    (memRead),
		.MemWrite   (memWrite),
		.Paused     (Paused)
	);

	datapath u_datapath
	(
		.Clk        (Clk),
		.Reset      (Reset),
		.LdMar      (ldMar),
		.LdIr       (ldIr),
		.LdBen      (ldBen),
		.LdCc       (ldCc),
		.LdReg      (ldReg),
		.LdPc       (ldPc),
		.GatePc     (gatePc),
		.GateMdr    (gateMdr),
		.GateAlu    (gateAlu),
		.GateMarMux (gateMarMux),
		.PcMux      (pcMux),
		.DrMux      (drMux),
		.Sr1Mux     (sr1Mux),
		.Sr2Mux     (sr2Mux),
		.Addr1Mux   (addr1Mux),
		.Addr2Mux   (addr2Mux),
		.AluOp      (aluOp),
		.LdMdrMem   (ldMdrMem),
		.RData      (rData),
		.Opcode     (opcode),
		.ImmFlag    (immFlag),
		.Ben        (ben),
		.Mar        (mar),
		.Mdr        (mdr),
		.IrDisplay  (IrDisplay)
	);

	apbMaster u_apbMaster
	(
		.Clk      (Clk),
		.Reset    (Reset),
		.MemRead  (memRead),
		.MemWrite (memWrite),
		.Mar      (mar),
		.Mdr      (mdr),
		.PRData   (PRData),
		.PReady   (PReady),
		.PAddr    (PAddr),
		.PSel     (PSel),
		.PEnable  (PEnable),
		.PWrite   (PWrite),
		.PWData   (PWData),
		.MemDone  (memDone),
		.LdMdrMem (ldMdrMem),
		.RData    (rData)
	);

endmodule

`default_nettype wire

//--- hw/apbMaster.sv
// APB master; runs one transfer per sequencer request and returns the read word with MemDone
`timescale 1ns/1ns
`default_nettype none

`include "slc3_settings.svh"

module apbMaster
(
	input  wire                          Clk,
	input  wire                          Reset,
	input  wire                          MemRead,
	input  wire                          MemWrite,
	input  wire [`SLC3_WORD_WIDTH-1:0]   Mar,
	input  wire [`SLC3_WORD_WIDTH-1:0]   Mdr,
	input  wire [`SLC3_WORD_WIDTH-1:0]   PRData,
	input  wire                          PReady,
	output logic [`SLC3_WORD_WIDTH-1:0]  PAddr,
	output logic                         PSel,
	output logic                         PEnable,
	output logic                         PWrite,
	output logic [`SLC3_WORD_WIDTH-1:0]  PWData,
	output logic                         MemDone,
	output logic                         LdMdrMem,
	output logic [`SLC3_WORD_WIDTH-1:0]  RData
);

	localparam logic [1:0] idle   = 2'd0;
	localparam logic [1:0] setup  = 2'd1;
	localparam logic [1:0] access = 2'd2;

	logic [1:0] state;
	logic       startXfer;
	logic       endXfer;

	// The request is still high while MemDone is out, so it must not restart
	assign startXfer = (state == idle) && (MemRead || MemWrite) && !MemDone;
	assign endXfer   = (state == access) && PReady;

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			state    <= idle;
			PSel     <= 1'b0;
			PEnable  <= 1'b0;
			PWrite   <= 1'b0;
			MemDone  <= 1'b0;
			LdMdrMem <= 1'b0;
		end
		else
		begin
			MemDone  <= endXfer;
			LdMdrMem <= endXfer && !PWrite;
			case (state)
				idle:
					if (startXfer)
					begin
						state  <= setup;
						PSel   <= 1'b1;
						PWrite <= MemWrite;
					end
				setup:
				begin
					state   <= access;
					PEnable <= 1'b1;
				end
				access:
					if (PReady)
					begin
						state   <= idle;
						PSel    <= 1'b0;
						PEnable <= 1'b0;
					end
				default:
					state <= idle;
			endcase
		end
	end

	// Address and write data held from setup to the next transfer
	always_ff @(posedge Clk)
	begin
		if (startXfer)
		begin
			PAddr  <= Mar;
			PWData <= Mdr;
		end
		if (endXfer && !PWrite)
			RData <= PRData;
	end

endmodule

`default_nettype wire

//--- hw/datapath.sv
// SLC-3 datapath with registers, ALU, address adder and the shared bus; steered by controlUnit
`timescale 1ns/1ns
`default_nettype none

`include "slc3_settings.svh"

module datapath import slc3Pkg::*;
(
	input  wire                          Clk,
	input  wire                          Reset,
	input  wire                          LdMar,
	input  wire                          LdIr,
	input  wire                          LdBen,
	input  wire                          LdCc,
	input  wire                          LdReg,
	input  wire                          LdPc,
	input  wire                          GatePc,
	input  wire                          GateMdr,
	input  wire                          GateAlu,
	input  wire                          GateMarMux,
	input  wire [1:0]                    PcMux,
	input  wire                          DrMux,
	input  wire                          Sr1Mux,
	input  wire                          Sr2Mux,
	input  wire                          Addr1Mux,
	input  wire [1:0]                    Addr2Mux,
	input  wire aluOpT                   AluOp,
	input  wire                          LdMdrMem,
	input  wire [`SLC3_WORD_WIDTH-1:0]   RData,
	output opcodeT                       Opcode,
	output logic                         ImmFlag,
	output logic                         Ben,
	output logic [`SLC3_WORD_WIDTH-1:0]  Mar,
	output logic [`SLC3_WORD_WIDTH-1:0]  Mdr,
	output logic [`SLC3_WORD_WIDTH-1:0]  IrDisplay
);

	localparam int Width   = `SLC3_WORD_WIDTH;
	localparam int RegIdxW = $clog2(`SLC3_NUM_REGS);

	instrWordT          ir;
	logic [Width-1:0]   pc;
	logic [Width-1:0]   bus;
	logic [Width-1:0]   regFile [`SLC3_NUM_REGS];
	logic [RegIdxW-1:0] drSel;
	logic [RegIdxW-1:0] sr1Sel;
	logic [Width-1:0]   sr1Val;
	logic [Width-1:0]   sr2Val;
	logic [Width-1:0]   aluOut;
	logic [Width-1:0]   addr1;
	logic [Width-1:0]   addr2;
	logic [Width-1:0]   addrSum;
	logic [10:0]        offLow;
	logic               n;
	logic               z;
	logic               p;

	assign Opcode    = ir.operate.opcode;
	assign ImmFlag   = ir.operate.immFlag;
	assign IrDisplay = ir;

	// ------------------------------------------------------------------
	// Register file and operand selection
	// ------------------------------------------------------------------
	assign drSel  = DrMux ? RegIdxW'(`SLC3_NUM_REGS - 1) : ir.operate.dr;
	assign sr1Sel = Sr1Mux ? ir.operate.sr1 : ir.operate.dr;
	assign sr1Val = regFile[sr1Sel];
	assign sr2Val = Sr2Mux ? {{(Width-5){ir.operate.src2[4]}}, ir.operate.src2}
	                       : regFile[ir.operate.src2[RegIdxW-1:0]];

	always_ff @(posedge Clk)
	begin
		if (LdReg)
			regFile[drSel] <= bus;
	end

	always_comb
	begin
		case (AluOp)
			aluAdd:  aluOut = sr1Val + sr2Val;
			aluAnd:  aluOut = sr1Val & sr2Val;
			aluNot:  aluOut = ~sr1Val;
			default: aluOut = sr1Val;
		endcase
	end

	// PC-relative and base-relative addresses
	assign offLow = {ir.offset.drCond[1:0], ir.offset.baseR, ir.offset.offset6};
	assign addr1  = Addr1Mux ? sr1Val : pc;

	always_comb
	begin
		case (Addr2Mux)
			2'd1:    addr2 = {{(Width-6){offLow[5]}}, offLow[5:0]};
			2'd2:    addr2 = {{(Width-9){offLow[8]}}, offLow[8:0]};
			2'd3:    addr2 = {{(Width-11){offLow[10]}}, offLow[10:0]};
			default: addr2 = '0;
		endcase
	end

	assign addrSum = addr1 + addr2;

	// At most one gate drives the bus
	always_comb
	begin
		if (GatePc)
			bus = pc;
		else if (GateMdr)
			bus = Mdr;
		else if (GateAlu)
			bus = aluOut;
		else if (GateMarMux)
			bus = addrSum;
		else
			bus = '0;
	end

	// ------------------------------------------------------------------
	// Architectural registers
	// ------------------------------------------------------------------
	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			pc  <= '0;
			ir  <= '0;
			n   <= 1'b0;
			z   <= 1'b0;
			p   <= 1'b0;
			Ben <= 1'b0;
		end
		else
		begin
			if (LdPc)
				case (PcMux)
					2'd0:    pc <= pc + 1'b1;
					2'd1:    pc <= bus;
					default: pc <= addrSum;
				endcase
			if (LdIr)
				ir <= bus;
			if (LdCc)
			begin
				n <= bus[Width-1];
				z <= (bus == '0);
				p <= !bus[Width-1] && (bus != '0);
			end
			if (LdBen)
				Ben <= (ir.offset.drCond[2] & n) | (ir.offset.drCond[1] & z)
				     | (ir.offset.drCond[0] & p);
		end
	end

	// Memory data comes from a read, otherwise MDR follows the ALU for STR
	always_ff @(posedge Clk)
	begin
		if (LdMar)
			Mar <= bus;
		if (LdMdrMem)
			Mdr <= RData;
		else if (GateAlu)
			Mdr <= bus;
	end

endmodule

`default_nettype wire

//--- hw/controlUnit.sv
// Instruction sequencer FSM; drives the datapath control word and the memory requests
`timescale 1ns/1ns
`default_nettype none

module controlUnit import slc3Pkg::*;
(
	input  wire         Clk,
	input  wire         Reset,
	input  wire         Run,
	input  wire         Continue,
	input  wire opcodeT Opcode,
	input  wire         ImmFlag,
	input  wire         Ben,
	input  wire         MemDone,
	output logic        LdMar,
	output logic        LdIr,
	output logic        LdBen,
	output logic        LdCc,
	output logic        LdReg,
	output logic        LdPc,
	output logic        GatePc,
	output logic        GateMdr,
	output logic        GateAlu,
	output logic        GateMarMux,
	output logic [1:0]  PcMux,
	output logic        DrMux,
	output logic        Sr1Mux,
	output logic        Sr2Mux,
	output logic        Addr1Mux,
	output logic [1:0]  Addr2Mux,
	output aluOpT       AluOp,
	output logic        MemRead,
	output logic        MemWrite,
	output logic        Paused
);

	localparam logic [4:0] halted      = 5'd0;
	localparam logic [4:0] fetchAddr   = 5'd1;
	localparam logic [4:0] fetchRead   = 5'd2;
	localparam logic [4:0] fetchIr     = 5'd3;
	localparam logic [4:0] decode      = 5'd4;
	localparam logic [4:0] pauseHigh   = 5'd5;
	localparam logic [4:0] pauseLow    = 5'd6;
	localparam logic [4:0] execAdd     = 5'd7;
	localparam logic [4:0] execAnd     = 5'd8;
	localparam logic [4:0] execNot     = 5'd9;
	localparam logic [4:0] execBr      = 5'd10;
	localparam logic [4:0] execBrTaken = 5'd11;
	localparam logic [4:0] execJmp     = 5'd12;
	localparam logic [4:0] execJsr     = 5'd13;
	localparam logic [4:0] execJsrJump = 5'd14;
	localparam logic [4:0] ldrAddr     = 5'd15;
	localparam logic [4:0] ldrRead     = 5'd16;
	localparam logic [4:0] ldrWrite    = 5'd17;
	localparam logic [4:0] strAddr     = 5'd18;
	localparam logic [4:0] strMdr      = 5'd19;
	localparam logic [4:0] strWrite    = 5'd20;

	logic [4:0] state;
	logic [4:0] nextState;

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
			state <= halted;
		else
			state <= nextState;
	end

	// ------------------------------------------------------------------
	// Next state
	// ------------------------------------------------------------------
	always_comb
	begin
		nextState = state;
		case (state)
			halted:
				if (Run)
					nextState = fetchAddr;
			fetchAddr:
				nextState = fetchRead;
			fetchRead:
				if (MemDone)
					nextState = fetchIr;
			fetchIr:
				nextState = decode;
			decode:
				case (Opcode)
					opAdd:   nextState = execAdd;
					opAnd:   nextState = execAnd;
					opNot:   nextState = execNot;
					opBr:    nextState = execBr;
					opJmp:   nextState = execJmp;
					opJsr:   nextState = execJsr;
					opLdr:   nextState = ldrAddr;
					opStr:   nextState = strAddr;
					opPause: nextState = pauseHigh;
					// Unsupported opcodes are skipped
					default: nextState = fetchAddr;
				endcase
			// Wait for a full press and release of Continue
			pauseHigh:
				if (Continue)
					nextState = pauseLow;
			pauseLow:
				if (!Continue)
					nextState = fetchAddr;
			execBr:
				nextState = Ben ? execBrTaken : fetchAddr;
			execJsr:
				nextState = execJsrJump;
			ldrAddr:
				nextState = ldrRead;
			ldrRead:
				if (MemDone)
					nextState = ldrWrite;
			strAddr:
				nextState = strMdr;
			strMdr:
				nextState = strWrite;
			strWrite:
				if (MemDone)
					nextState = fetchAddr;
			default:
				nextState = fetchAddr;
		endcase
	end

	// ------------------------------------------------------------------
	// Control word with everything inactive unless the state asks for it
	// ------------------------------------------------------------------
	always_comb
	begin
		LdMar      = 1'b0;
		LdIr       = 1'b0;
		LdBen      = 1'b0;
		LdCc       = 1'b0;
		LdReg      = 1'b0;
		LdPc       = 1'b0;
		GatePc     = 1'b0;
		GateMdr    = 1'b0;
		GateAlu    = 1'b0;
		GateMarMux = 1'b0;
		PcMux      = 2'd0;
		DrMux      = 1'b0;
		Sr1Mux     = 1'b0;
		Sr2Mux     = 1'b0;
		Addr1Mux   = 1'b0;
		Addr2Mux   = 2'd0;
		AluOp      = aluAdd;
		MemRead    = 1'b0;
		MemWrite   = 1'b0;
		Paused     = 1'b0;
		case (state)
			// MAR gets PC while PC steps to PC + 1
			fetchAddr:
			begin
				GatePc = 1'b1;
				LdMar  = 1'b1;
				LdPc   = 1'b1;
			end
			fetchRead, ldrRead:
				MemRead = 1'b1;
			fetchIr:
			begin
				GateMdr = 1'b1;
				LdIr    = 1'b1;
			end
			decode:
				LdBen = 1'b1;
			pauseHigh, pauseLow:
				Paused = 1'b1;
			execAdd, execAnd, execNot:
			begin
				Sr1Mux  = 1'b1;
				Sr2Mux  = ImmFlag;
				GateAlu = 1'b1;
				LdReg   = 1'b1;
				LdCc    = 1'b1;
				if (state == execAnd)
					AluOp = aluAnd;
				else if (state == execNot)
					AluOp = aluNot;
			end
			// PC plus the nine-bit offset
			execBrTaken:
			begin
				Addr2Mux = 2'd2;
				PcMux    = 2'd2;
				LdPc     = 1'b1;
			end
			// Base register through the ALU onto the bus
			execJmp:
			begin
				Sr1Mux  = 1'b1;
				AluOp   = aluPassA;
				GateAlu = 1'b1;
				PcMux   = 2'd1;
				LdPc    = 1'b1;
			end
			// Return address into R7
			execJsr:
			begin
				GatePc = 1'b1;
				DrMux  = 1'b1;
				LdReg  = 1'b1;
			end
			execJsrJump:
			begin
				Addr2Mux = 2'd3;
				PcMux    = 2'd2;
				LdPc     = 1'b1;
			end
			// Base register plus six-bit offset into MAR
			ldrAddr, strAddr:
			begin
				Sr1Mux     = 1'b1;
				Addr1Mux   = 1'b1;
				Addr2Mux   = 2'd1;
				GateMarMux = 1'b1;
				LdMar      = 1'b1;
			end
			ldrWrite:
			begin
				GateMdr = 1'b1;
				LdReg   = 1'b1;
				LdCc    = 1'b1;
			end
			// Source register through the ALU into MDR
			strMdr:
			begin
				AluOp   = aluPassA;
				GateAlu = 1'b1;
			end
			strWrite:
				MemWrite = 1'b1;
			default:
			begin
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hw/slc3Pkg.sv
// Opcode, ALU operation and instruction word types; import into blocks that decode the IR
`default_nettype none

`include "slc3_settings.svh"

package slc3Pkg;

	typedef enum logic [3:0]
	{
		opBr    = `SLC3_OP_BR,
		opAdd   = `SLC3_OP_ADD,
		opJsr   = `SLC3_OP_JSR,
		opAnd   = `SLC3_OP_AND,
		opLdr   = `SLC3_OP_LDR,
		opStr   = `SLC3_OP_STR,
		opNot   = `SLC3_OP_NOT,
		opJmp   = `SLC3_OP_JMP,
		opPause = `SLC3_OP_PAUSE
	} opcodeT;

	// passA routes the first source unchanged, used by JMP and STR
	typedef enum logic [1:0]
	{
		aluAdd   = 2'b00,
		aluAnd   = 2'b01,
		aluNot   = 2'b10,
		aluPassA = 2'b11
	} aluOpT;

	typedef union packed
	{
		// ADD, AND, NOT and JMP layout
		struct packed
		{
			opcodeT     opcode;
			logic [2:0] dr;
			logic [2:0] sr1;
			logic       immFlag;
			// Immediate, or second source in the low three bits
			logic [4:0] src2;
		} operate;
		// LDR, STR, BR and JSR layout
		struct packed
		{
			opcodeT     opcode;
			logic [2:0] drCond;
			logic [2:0] baseR;
			logic [5:0] offset6;
		} offset;
	} instrWordT;

endpackage

`default_nettype wire

//--- hw/slc3_settings.svh
// Word width, register count and opcode codes; include wherever these constants are needed
`ifndef SLC3_SETTINGS_SVH
`define SLC3_SETTINGS_SVH

// Datapath sizing
`define SLC3_WORD_WIDTH 16
`define SLC3_NUM_REGS   8

// Opcode field values of the supported LC-3 subset
`define SLC3_OP_BR    4'b0000
`define SLC3_OP_ADD   4'b0001
`define SLC3_OP_JSR   4'b0100
`define SLC3_OP_AND   4'b0101
`define SLC3_OP_LDR   4'b0110
`define SLC3_OP_STR   4'b0111
`define SLC3_OP_NOT   4'b1001
`define SLC3_OP_JMP   4'b1100
`define SLC3_OP_PAUSE 4'b1101

`endif
